// ==== Makefile ====
# Verilator build and run of the packet buffer testbench.

VERILATOR ?= verilator
TOP       ?= pkt_buffer_tb
FILELIST  ?= pkt_buffer.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --assert --timing -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from grep, so a run without the pass line fails.
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== axis_fifo/axis_fifo.sv ====
`timescale 1ns/1ns

module axis_fifo #(
  parameter int ADDR_WIDTH     = 4,
  parameter bit DROP_WHEN_FULL = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst,

  // Write side.
  input  pkt_pkg::stream_beat_t s_beat,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  logic                  s_bad,

  // Read side.
  output pkt_pkg::stream_beat_t m_beat,
  output logic                  m_valid,
  input  logic                  m_ready,

  // Frame status pulses.
  output logic                  good_frame,
  output logic                  bad_frame,
  output logic                  overflow
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  typedef logic [ADDR_WIDTH:0]   ptr_t;    // Extra bit tells full from empty.
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  pkt_pkg::stream_beat_t mem [DEPTH];

  ptr_t wr_ptr;            // Committed, visible to the reader.
  ptr_t wr_ptr_next;
  ptr_t wr_ptr_cur;        // Frame being written.
  ptr_t wr_ptr_cur_next;
  ptr_t rd_ptr;
  ptr_t rd_ptr_next;

  logic full_cur;
  logic full_wr;
  logic empty;

  logic write;
  logic read;
  logic store_output;

  logic drop_frame;
  logic drop_frame_next;
  logic good_next;
  logic bad_next;
  logic overflow_next;

  pkt_pkg::stream_beat_t mem_rd_beat;
  logic                  mem_rd_valid;
  logic                  mem_rd_valid_next;
  logic                  m_valid_next;

  assign full_cur = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                    (addr_t'(wr_ptr_cur) == addr_t'(rd_ptr));
  // Current frame alone fills the whole memory.
  assign full_wr  = (wr_ptr[ADDR_WIDTH] != wr_ptr_cur[ADDR_WIDTH]) &&
                    (addr_t'(wr_ptr) == addr_t'(wr_ptr_cur));
  assign empty    = (wr_ptr == rd_ptr);

  assign s_ready = !full_cur || full_wr || DROP_WHEN_FULL;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    write           = 1'b0;
    drop_frame_next = drop_frame;
    good_next       = 1'b0;
    bad_next        = 1'b0;
    overflow_next   = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    if (s_valid && s_ready) begin
      if (full_cur || full_wr || drop_frame) begin
        // Frame does not fit. Swallow it up to its last beat.
        drop_frame_next = 1'b1;
        if (s_beat.last) begin
          wr_ptr_cur_next = wr_ptr;
          drop_frame_next = 1'b0;
          // A length error outranks lack of space.
          if (s_bad) begin
            bad_next = 1'b1;
          end else begin
            overflow_next = 1'b1;
          end
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_beat.last) begin
          if (s_bad) begin
            wr_ptr_cur_next = wr_ptr;   // Rewind.
            bad_next        = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur + 1'b1;   // Commit.
            good_next   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
      good_frame <= 1'b0;
      bad_frame  <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      drop_frame <= drop_frame_next;
      good_frame <= good_next;
      bad_frame  <= bad_next;
      overflow   <= overflow_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr_t'(wr_ptr_cur)] <= s_beat;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read pipeline
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    read              = 1'b0;
    rd_ptr_next       = rd_ptr;
    mem_rd_valid_next = mem_rd_valid;
    if (store_output || !mem_rd_valid) begin
      if (!empty) begin
        read              = 1'b1;
        rd_ptr_next       = rd_ptr + 1'b1;
        mem_rd_valid_next = 1'b1;
      end else begin
        mem_rd_valid_next = 1'b0;
      end
    end
  end

  // Output register takes a new beat when empty or accepted.
  assign store_output = m_ready || !m_valid;
  assign m_valid_next = store_output ? mem_rd_valid : m_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr       <= '0;
      mem_rd_valid <= 1'b0;
      m_valid      <= 1'b0;
    end else begin
      rd_ptr       <= rd_ptr_next;
      mem_rd_valid <= mem_rd_valid_next;
      m_valid      <= m_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      mem_rd_beat <= mem[addr_t'(rd_ptr)];
    end
    if (store_output) begin
      m_beat <= mem_rd_beat;
    end
  end

endmodule

// ==== bench/pkt_buffer_tb.sv ====
`timescale 1ns/1ns

module pkt_buffer_tb;

  localparam int DEPTH     = 2 ** pkt_pkg::DEF_ADDR_WIDTH;
  localparam int MIN_BEATS = pkt_pkg::DEF_MIN_BEATS;
  localparam int MAX_BEATS = pkt_pkg::DEF_MAX_BEATS;

  localparam logic [31:0] SEED = 32'd8611;

  logic                  clk;
  logic                  rst;
  pkt_pkg::stream_beat_t s_beat;
  logic                  s_valid;
  logic                  s_ready;
  pkt_pkg::stream_beat_t m_beat;
  logic                  m_valid;
  logic                  m_ready = 1'b1;
  pkt_pkg::frame_count_t good_count;
  pkt_pkg::frame_count_t bad_count;
  pkt_pkg::frame_count_t overflow_count;

  pkt_pkg::stream_beat_t exp_q[$];   // Beats of committed frames, in output order.

  int unsigned exp_good     = 0;
  int unsigned exp_bad      = 0;
  int unsigned exp_overflow = 0;
  int unsigned beats_sent   = 0;
  int unsigned cycle_cnt    = 0;

  logic [31:0] stim_state;
  logic [31:0] ready_state;
  logic        random_ready;

  logic                  held_stall;   // Output was stalled at the last edge.
  pkt_pkg::stream_beat_t held_beat;

  pkt_buffer pkt_buffer_i (
    .clk            (clk),
    .rst            (rst),
    .s_beat         (s_beat),
    .s_valid        (s_valid),
    .s_ready        (s_ready),
    .m_beat         (m_beat),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

  initial clk = 1'b0;

  always #20 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Value in 0 to n-1 from the stimulus generator.
  function automatic int unsigned pick(input int unsigned n);
    stim_state = lcg_next(stim_state);
    return (stim_state >> 16) % n;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    abort_run($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h",
                        name, expected, actual));
  endtask

  task automatic check_counters();
    assert (good_count == pkt_pkg::frame_count_t'(exp_good))
      else report_mismatch("good_count", exp_good, 32'(good_count));
    assert (bad_count == pkt_pkg::frame_count_t'(exp_bad))
      else report_mismatch("bad_count", exp_bad, 32'(bad_count));
    assert (overflow_count == pkt_pkg::frame_count_t'(exp_overflow))
      else report_mismatch("overflow_count", exp_overflow, 32'(overflow_count));
  endtask

  // Sends one frame of len beats, then idles for gap cycles.
  task automatic send_frame(input int len, input int gap);
    pkt_pkg::stream_beat_t frame_q[$];
    pkt_pkg::stream_beat_t beat;
    logic                  good;
    int                    i;
    good = (len >= MIN_BEATS) && (len <= MAX_BEATS) && (len <= DEPTH);
    if (good) begin
      // Hold off until the memory surely has room.
      while (exp_q.size() + len > DEPTH) begin
        @(posedge clk);
        #2;
      end
    end
    for (i = 0; i < len; i++) begin
      beat.data = pkt_pkg::beat_data_t'(pick(256));
      beat.last = (i == len - 1);
      s_beat    = beat;
      s_valid   = 1'b1;
      // Ready comes from registers, so it is settled here for the next edge.
      while (!s_ready) begin
        @(posedge clk);
        #2;
      end
      @(posedge clk);
      frame_q.push_back(beat);
      #2;
      beats_sent++;
    end
    s_valid = 1'b0;
    if (good) begin
      foreach (frame_q[k]) begin
        exp_q.push_back(frame_q[k]);
      end
    end
    if ((len < MIN_BEATS) || (len > MAX_BEATS)) begin
      exp_bad++;
    end else if (len > DEPTH) begin
      exp_overflow++;
    end else begin
      exp_good++;
    end
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
    repeat (3) @(posedge clk);   // Counters trail the last beat by two cycles.
    #2;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    #2;
    if (random_ready) begin
      ready_state = lcg_next(ready_state);
      m_ready     = (ready_state[27:26] != 2'b00);   // About three in four.
    end else begin
      m_ready = 1'b1;
    end
  end

  always @(posedge clk) begin : monitor
    pkt_pkg::stream_beat_t exp_beat;
    if (rst) begin
      held_stall <= 1'b0;
    end else begin
      if (held_stall) begin
        assert (m_valid) else report_mismatch("m_valid", 32'd1, 32'(m_valid));
        assert (m_beat == held_beat)
          else report_mismatch("m_beat", 32'(held_beat), 32'(m_beat));
      end
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("Output beat arrived while no frame was expected");
        end else begin
          exp_beat = exp_q.pop_front();
          assert (m_beat == exp_beat)
            else report_mismatch("m_beat", 32'(exp_beat), 32'(m_beat));
        end
      end
      held_stall <= m_valid && !m_ready;
      held_beat  <= m_beat;
    end
  end

  // Drop mode never stalls the input.
  assert property (@(posedge clk) disable iff (rst) s_ready)
    else report_mismatch("s_ready", 32'd1, 32'(s_ready));

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > 40 * beats_sent + 2000) begin
      abort_run("Timeout, the run did not finish in time");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : stimulus
    int n;
    int len;
    stim_state   = SEED;
    ready_state  = ~SEED;
    random_ready = 1'b0;
    rst          = 1'b1;
    s_valid      = 1'b0;
    s_beat       = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    assert (m_valid == 1'b0) else report_mismatch("m_valid", 32'd0, 32'(m_valid));
    assert (s_ready == 1'b1) else report_mismatch("s_ready", 32'd1, 32'(s_ready));
    check_counters();

    // Back to back, output always ready.
    for (len = MIN_BEATS; len <= DEPTH; len++) begin
      send_frame(len, 0);
    end
    for (n = 0; n < 10; n++) begin
      send_frame(MIN_BEATS + pick(DEPTH - MIN_BEATS + 1), 0);
    end
    wait_drain();
    check_counters();

    // Short, too big for memory, too long.
    send_frame(1, 1);
    send_frame(DEPTH + 1, 1);
    send_frame(20, 0);
    send_frame(MAX_BEATS, 2);
    send_frame(MAX_BEATS + 1, 0);
    send_frame(30, 1);
    send_frame(5, 0);
    send_frame(1, 0);
    wait_drain();
    check_counters();

    @(negedge clk);
    random_ready = 1'b1;
    @(posedge clk);
    #2;

    for (n = 0; n < 60; n++) begin
      send_frame(MIN_BEATS + pick(DEPTH - MIN_BEATS + 1), pick(4));
    end
    wait_drain();
    check_counters();

    // Every length class mixed.
    for (n = 0; n < 40; n++) begin
      send_frame(1 + pick(32), pick(3));
    end
    wait_drain();
    check_counters();

    $display("Test OK");
    $finish;
  end

endmodule

// ==== common/pkt_pkg.sv ====
package pkt_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat and counter types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [7:0] beat_data_t;   // One payload byte.

  // One stream beat, payload plus end-of-frame flag.
  typedef struct packed {
    beat_data_t data;
    logic       last;
  } stream_beat_t;

  typedef logic [15:0] frame_count_t;   // Frame tally.

  localparam frame_count_t FRAME_COUNT_MAX = '1;   // Saturation value.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Default sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Buffer depth is 2**DEF_ADDR_WIDTH beats.
  localparam int DEF_ADDR_WIDTH = 4;

  // Legal frame length range, in beats.
  localparam int DEF_MIN_BEATS = 2;
  localparam int DEF_MAX_BEATS = 24;

endpackage

// ==== pkt_buffer.f ====
common/pkt_pkg.sv
rtl/frame_len_check.sv
axis_fifo/axis_fifo.sv
rtl/frame_stats.sv
rtl/pkt_buffer.sv
bench/pkt_buffer_tb.sv

// ==== rtl/frame_len_check.sv ====
`timescale 1ns/1ns

module frame_len_check #(
  parameter int MIN_BEATS = 2,
  parameter int MAX_BEATS = 24
) (
  input  logic                  clk,
  input  logic                  rst,

  // Upstream stream.
  input  pkt_pkg::stream_beat_t s_beat,
  input  logic                  s_valid,
  output logic                  s_ready,

  // Towards the frame FIFO.
  output pkt_pkg::stream_beat_t chk_beat,
  output logic                  chk_valid,
  input  logic                  chk_ready,
  output logic                  chk_bad
);

  // Room for MAX_BEATS+2 so count plus one never wraps.
  localparam int CNT_WIDTH = $clog2(MAX_BEATS + 3);

  typedef logic [CNT_WIDTH-1:0] beat_cnt_t;

  localparam beat_cnt_t CNT_SAT = beat_cnt_t'(MAX_BEATS + 1);

  beat_cnt_t beat_cnt;
  beat_cnt_t beats_incl;    // Beats of the frame so far, current beat included.
  logic      xfer;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pass-through handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign chk_beat  = s_beat;
  assign chk_valid = s_valid;
  assign s_ready   = chk_ready;

  assign xfer = s_valid && chk_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Length check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign beats_incl = beat_cnt + 1'b1;

  always_comb begin
    chk_bad = 1'b0;
    if (s_beat.last) begin
      chk_bad = (beats_incl < beat_cnt_t'(MIN_BEATS)) ||
                (beats_incl > beat_cnt_t'(MAX_BEATS));
    end
  end

  // Saturates past the upper limit, so long frames stay flagged.
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (xfer) begin
      if (s_beat.last) begin
        beat_cnt <= '0;
      end else if (beat_cnt != CNT_SAT) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/frame_stats.sv ====
`timescale 1ns/1ns

module frame_stats (
  input  logic                  clk,
  input  logic                  rst,

  // One-cycle pulses from the frame FIFO.
  input  logic                  good_frame,
  input  logic                  bad_frame,
  input  logic                  overflow,

  output pkt_pkg::frame_count_t good_count,
  output pkt_pkg::frame_count_t bad_count,
  output pkt_pkg::frame_count_t overflow_count
);

  // Increment unless already at all ones.
  function automatic pkt_pkg::frame_count_t sat_inc(
    input pkt_pkg::frame_count_t cnt,
    input logic                  inc
  );
    pkt_pkg::frame_count_t res;
    res = cnt;
    if (inc && (cnt != pkt_pkg::FRAME_COUNT_MAX)) begin
      res = cnt + 1'b1;
    end
    return res;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      good_count     <= '0;
      bad_count      <= '0;
      overflow_count <= '0;
    end else begin
      good_count     <= sat_inc(good_count, good_frame);
      bad_count      <= sat_inc(bad_count, bad_frame);
      overflow_count <= sat_inc(overflow_count, overflow);   // Dropped for space.
    end
  end

endmodule

// ==== rtl/pkt_buffer.sv ====
`timescale 1ns/1ns

module pkt_buffer #(
  parameter int ADDR_WIDTH     = pkt_pkg::DEF_ADDR_WIDTH,
  parameter int MIN_BEATS      = pkt_pkg::DEF_MIN_BEATS,
  parameter int MAX_BEATS      = pkt_pkg::DEF_MAX_BEATS,
  parameter bit DROP_WHEN_FULL = 1'b1
) (
  input  logic                  clk,
  input  logic                  rst,

  input  pkt_pkg::stream_beat_t s_beat,
  input  logic                  s_valid,
  output logic                  s_ready,

  output pkt_pkg::stream_beat_t m_beat,
  output logic                  m_valid,
  input  logic                  m_ready,

  output pkt_pkg::frame_count_t good_count,
  output pkt_pkg::frame_count_t bad_count,
  output pkt_pkg::frame_count_t overflow_count
);

  // Checker to FIFO.
  pkt_pkg::stream_beat_t chk_beat;
  logic                  chk_valid;
  logic                  chk_ready;
  logic                  chk_bad;

  // FIFO to statistics.
  logic good_frame;
  logic bad_frame;
  logic overflow;

  frame_len_check #(
    .MIN_BEATS (MIN_BEATS),
    .MAX_BEATS (MAX_BEATS)
  ) frame_len_check_i (
    .clk       (clk),
    .rst       (rst),
    .s_beat    (s_beat),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .chk_beat  (chk_beat),
    .chk_valid (chk_valid),
    .chk_ready (chk_ready),
    .chk_bad   (chk_bad)
  );

  axis_fifo #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DROP_WHEN_FULL (DROP_WHEN_FULL)
  ) axis_fifo_i (
    .clk        (clk),
    .rst        (rst),
    .s_beat     (chk_beat),
    .s_valid    (chk_valid),
    .s_ready    (chk_ready),
    .s_bad      (chk_bad),
    .m_beat     (m_beat),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .good_frame (good_frame),
    .bad_frame  (bad_frame),
    .overflow   (overflow)
  );

  frame_stats frame_stats_i (
    .clk            (clk),
    .rst            (rst),
    .good_frame     (good_frame),
    .bad_frame      (bad_frame),
    .overflow       (overflow),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

endmodule
